// File: common/rv_params.svh
`ifndef RV_PARAMS_SVH
`define RV_PARAMS_SVH

// Data and address width
`define XLEN 32

// Architectural registers including x0
`define REG_COUNT 32

// Data RAM depth in 32-bit words
`define DMEM_WORDS 256

`endif

// File: common/isa_pkg.sv
package isa_pkg;

    // RV32I major opcodes handled by the core
    typedef enum logic [6:0] {
        OPC_OP     = 7'b0110011,
        OPC_OP_IMM = 7'b0010011,
        OPC_LOAD   = 7'b0000011,
        OPC_STORE  = 7'b0100011,
        OPC_BRANCH = 7'b1100011,
        OPC_LUI    = 7'b0110111,
        OPC_AUIPC  = 7'b0010111,
        OPC_JAL    = 7'b1101111,
        OPC_JALR   = 7'b1100111
    } opcode_e;

    // One code per instruction, numbered in sequence from ALU_ADD
    typedef enum logic [5:0] {
        ALU_NOP   = 6'd0,
        ALU_ADD   = 6'd1,  ALU_SUB,   ALU_SLL,   ALU_SLT,   ALU_SLTU,  // Register ops
        ALU_XOR,  ALU_SRL,  ALU_SRA,   ALU_OR,    ALU_AND,
        ALU_ADDI  = 6'd11, ALU_SLTI,  ALU_SLTIU, ALU_XORI,  ALU_ORI,   // Immediate ops
        ALU_ANDI, ALU_SLLI, ALU_SRLI,  ALU_SRAI,
        ALU_LB    = 6'd20, ALU_LH,    ALU_LW,    ALU_LBU,   ALU_LHU,   // Loads
        ALU_SB    = 6'd25, ALU_SH,    ALU_SW,                          // Stores
        ALU_BEQ   = 6'd28, ALU_BNE,   ALU_BLT,   ALU_BGE,   ALU_BLTU,  // Branches
        ALU_BGEU,
        ALU_LUI   = 6'd34, ALU_AUIPC, ALU_JAL,   ALU_JALR
    } alu_op_e;

    // Source of the value written back to rd
    typedef enum logic [1:0] {
        WB_NONE = 2'd0,
        WB_MEM  = 2'd1, // Load data
        WB_LINK = 2'd2, // pc + 4
        WB_ALU  = 2'd3
    } wb_sel_e;

endpackage

// File: common/core_pkg.sv
`include "rv_params.svh"

package core_pkg;

    localparam int REG_IDX_W = $clog2(`REG_COUNT);

    typedef struct packed {
        logic [REG_IDX_W-1:0] rs1;
        logic [REG_IDX_W-1:0] rs2;
        logic [REG_IDX_W-1:0] rd;
        logic                 rs1_en;    // Instruction reads rs1
        logic                 rs2_en;    // Instruction reads rs2
        logic                 reg_write;
        logic                 mem_read;
        logic                 mem_write;
        logic [2:0]           funct3;
        logic [`XLEN-1:0]     imm;       // Sign-extended immediate
        isa_pkg::alu_op_e     alu_op;
        isa_pkg::wb_sel_e     wb_sel;
        logic                 jump;      // JAL or JALR
    } decode_t;

    typedef struct packed {
        logic [`XLEN-1:0] alu_result;    // Also branch or jump target
        logic             branch_taken;
        logic [`XLEN-1:0] store_data;
    } exec_t;

    typedef struct packed {
        logic                 valid;
        logic [REG_IDX_W-1:0] rd;
        logic [`XLEN-1:0]     data;
    } wb_t;

endpackage

// File: fetch/fetch_unit.sv
`timescale 1ns/1ps
`include "rv_params.svh"

module fetch_unit (
    input  logic              clk,
    input  logic              reset,
    input  logic              jump,
    input  core_pkg::exec_t   exec,
    output logic [`XLEN-1:0]  pc
);

    logic [`XLEN-1:0] pc_seq;
    logic [`XLEN-1:0] pc_next;
    logic             redirect;

    assign pc_seq   = pc + `XLEN'd4;
    assign redirect = jump || exec.branch_taken;  // Target comes from the ALU
    assign pc_next  = redirect ? exec.alu_result : pc_seq;

    always_ff @(posedge clk) begin
        if (reset) begin
            pc <= '0;
        end else begin
            pc <= pc_next;
        end
    end

endmodule

// File: decode/control_unit.sv
`timescale 1ns/1ps
`include "rv_params.svh"

module control_unit (
    input  logic [`XLEN-1:0] instruction,
    output core_pkg::decode_t ctrl
);

    logic [6:0]       funct7;
    logic [2:0]       funct3;
    logic [`XLEN-1:0] imm_i;
    logic [`XLEN-1:0] imm_s;
    logic [`XLEN-1:0] imm_b;
    logic [`XLEN-1:0] imm_u;
    logic [`XLEN-1:0] imm_j;

    assign funct7 = instruction[31:25];
    assign funct3 = instruction[14:12];

    assign imm_i = {{20{instruction[31]}}, instruction[31:20]};
    assign imm_s = {{20{instruction[31]}}, instruction[31:25], instruction[11:7]};
    assign imm_b = {{19{instruction[31]}}, instruction[31], instruction[7],
                    instruction[30:25], instruction[11:8], 1'b0};
    assign imm_u = {instruction[31:12], 12'b0};
    assign imm_j = {{11{instruction[31]}}, instruction[31], instruction[19:12],
                    instruction[20], instruction[30:21], 1'b0};

    always_comb begin
        ctrl        = '0;
        ctrl.rs1    = instruction[19:15];  // Only meaningful with rs1_en
        ctrl.rs2    = instruction[24:20];
        ctrl.rd     = instruction[11:7];
        ctrl.funct3 = funct3;
        ctrl.alu_op = isa_pkg::ALU_NOP;
        ctrl.wb_sel = isa_pkg::WB_NONE;

        case (isa_pkg::opcode_e'(instruction[6:0]))
            isa_pkg::OPC_OP: begin
                ctrl.rs1_en    = 1'b1;
                ctrl.rs2_en    = 1'b1;
                ctrl.reg_write = 1'b1;
                ctrl.wb_sel    = isa_pkg::WB_ALU;
                case ({funct7, funct3})
                    {7'h00, 3'b000}: ctrl.alu_op = isa_pkg::ALU_ADD;
                    {7'h20, 3'b000}: ctrl.alu_op = isa_pkg::ALU_SUB;
                    {7'h00, 3'b001}: ctrl.alu_op = isa_pkg::ALU_SLL;
                    {7'h00, 3'b010}: ctrl.alu_op = isa_pkg::ALU_SLT;
                    {7'h00, 3'b011}: ctrl.alu_op = isa_pkg::ALU_SLTU;
                    {7'h00, 3'b100}: ctrl.alu_op = isa_pkg::ALU_XOR;
                    {7'h00, 3'b101}: ctrl.alu_op = isa_pkg::ALU_SRL;
                    {7'h20, 3'b101}: ctrl.alu_op = isa_pkg::ALU_SRA;
                    {7'h00, 3'b110}: ctrl.alu_op = isa_pkg::ALU_OR;
                    {7'h00, 3'b111}: ctrl.alu_op = isa_pkg::ALU_AND;
                    default:         ctrl.alu_op = isa_pkg::ALU_NOP;
                endcase
            end
            isa_pkg::OPC_OP_IMM: begin
                ctrl.rs1_en    = 1'b1;
                ctrl.reg_write = 1'b1;
                ctrl.wb_sel    = isa_pkg::WB_ALU;
                ctrl.imm       = imm_i;
                case (funct3)
                    3'b000: ctrl.alu_op = isa_pkg::ALU_ADDI;
                    3'b010: ctrl.alu_op = isa_pkg::ALU_SLTI;
                    3'b011: ctrl.alu_op = isa_pkg::ALU_SLTIU;
                    3'b100: ctrl.alu_op = isa_pkg::ALU_XORI;
                    3'b110: ctrl.alu_op = isa_pkg::ALU_ORI;
                    3'b111: ctrl.alu_op = isa_pkg::ALU_ANDI;
                    3'b001: if (funct7 == 7'h00) ctrl.alu_op = isa_pkg::ALU_SLLI;
                    default: begin  // funct7 picks logical or arithmetic right shift
                        if (funct7 == 7'h00) ctrl.alu_op = isa_pkg::ALU_SRLI;
                        else if (funct7 == 7'h20) ctrl.alu_op = isa_pkg::ALU_SRAI;
                    end
                endcase
            end
            isa_pkg::OPC_LOAD: begin
                ctrl.rs1_en    = 1'b1;
                ctrl.reg_write = 1'b1;
                ctrl.mem_read  = 1'b1;
                ctrl.wb_sel    = isa_pkg::WB_MEM;
                ctrl.imm       = imm_i;
                case (funct3)
                    3'b000:  ctrl.alu_op = isa_pkg::ALU_LB;
                    3'b001:  ctrl.alu_op = isa_pkg::ALU_LH;
                    3'b010:  ctrl.alu_op = isa_pkg::ALU_LW;
                    3'b100:  ctrl.alu_op = isa_pkg::ALU_LBU;
                    3'b101:  ctrl.alu_op = isa_pkg::ALU_LHU;
                    default: ctrl.alu_op = isa_pkg::ALU_NOP;
                endcase
            end
            isa_pkg::OPC_STORE: begin
                ctrl.rs1_en    = 1'b1;
                ctrl.rs2_en    = 1'b1;  // Store data
                ctrl.mem_write = 1'b1;
                ctrl.imm       = imm_s;
                case (funct3)
                    3'b000:  ctrl.alu_op = isa_pkg::ALU_SB;
                    3'b001:  ctrl.alu_op = isa_pkg::ALU_SH;
                    3'b010:  ctrl.alu_op = isa_pkg::ALU_SW;
                    default: ctrl.alu_op = isa_pkg::ALU_NOP;
                endcase
            end
            isa_pkg::OPC_BRANCH: begin
                ctrl.rs1_en = 1'b1;
                ctrl.rs2_en = 1'b1;
                ctrl.imm    = imm_b;
                case (funct3)
                    3'b000:  ctrl.alu_op = isa_pkg::ALU_BEQ;
                    3'b001:  ctrl.alu_op = isa_pkg::ALU_BNE;
                    3'b100:  ctrl.alu_op = isa_pkg::ALU_BLT;
                    3'b101:  ctrl.alu_op = isa_pkg::ALU_BGE;
                    3'b110:  ctrl.alu_op = isa_pkg::ALU_BLTU;
                    3'b111:  ctrl.alu_op = isa_pkg::ALU_BGEU;
                    default: ctrl.alu_op = isa_pkg::ALU_NOP;
                endcase
            end
            isa_pkg::OPC_LUI, isa_pkg::OPC_AUIPC: begin
                ctrl.reg_write = 1'b1;
                ctrl.wb_sel    = isa_pkg::WB_ALU;
                ctrl.imm       = imm_u;
                ctrl.alu_op    = instruction[5] ? isa_pkg::ALU_LUI : isa_pkg::ALU_AUIPC;
            end
            isa_pkg::OPC_JAL: begin
                ctrl.reg_write = 1'b1;
                ctrl.wb_sel    = isa_pkg::WB_LINK;
                ctrl.imm       = imm_j;
                ctrl.jump      = 1'b1;
                ctrl.alu_op    = isa_pkg::ALU_JAL;
            end
            isa_pkg::OPC_JALR: begin
                ctrl.rs1_en    = 1'b1;
                ctrl.reg_write = 1'b1;
                ctrl.wb_sel    = isa_pkg::WB_LINK;
                ctrl.imm       = imm_i;
                ctrl.jump      = 1'b1;
                ctrl.alu_op    = (funct3 == 3'b000) ? isa_pkg::ALU_JALR : isa_pkg::ALU_NOP;
            end
            default: ctrl.alu_op = isa_pkg::ALU_NOP;
        endcase

        // Illegal encodings retire as a bubble
        if (ctrl.alu_op == isa_pkg::ALU_NOP) begin
            ctrl.reg_write = 1'b0;
            ctrl.mem_read  = 1'b0;
            ctrl.mem_write = 1'b0;
            ctrl.jump      = 1'b0;
            ctrl.wb_sel    = isa_pkg::WB_NONE;
        end
    end

endmodule

// File: execute/alu.sv
`timescale 1ns/1ps
`include "rv_params.svh"

module alu (
    input  core_pkg::decode_t ctrl,
    input  logic [`XLEN-1:0]  rs1_data,
    input  logic [`XLEN-1:0]  rs2_data,
    input  logic [`XLEN-1:0]  pc,
    output logic [`XLEN-1:0]  result,
    output logic              branch_taken
);

    logic [`XLEN-1:0] rs1_imm;  // Immediate ops, load/store address, JALR
    logic [`XLEN-1:0] pc_imm;   // Branch and JAL targets, AUIPC
    logic             lt;
    logic             ltu;
    logic             eq;

    assign rs1_imm = rs1_data + ctrl.imm;
    assign pc_imm  = pc + ctrl.imm;
    assign lt      = $signed(rs1_data) < $signed(rs2_data);
    assign ltu     = rs1_data < rs2_data;
    assign eq      = rs1_data == rs2_data;

    always_comb begin
        case (ctrl.alu_op)
            isa_pkg::ALU_ADD:   result = rs1_data + rs2_data;
            isa_pkg::ALU_SUB:   result = rs1_data - rs2_data;
            isa_pkg::ALU_SLL:   result = rs1_data << rs2_data[4:0];
            isa_pkg::ALU_SLT:   result = {{(`XLEN-1){1'b0}}, lt};
            isa_pkg::ALU_SLTU:  result = {{(`XLEN-1){1'b0}}, ltu};
            isa_pkg::ALU_XOR:   result = rs1_data ^ rs2_data;
            isa_pkg::ALU_SRL:   result = rs1_data >> rs2_data[4:0];
            isa_pkg::ALU_SRA:   result = $signed(rs1_data) >>> rs2_data[4:0];
            isa_pkg::ALU_OR:    result = rs1_data | rs2_data;
            isa_pkg::ALU_AND:   result = rs1_data & rs2_data;
            isa_pkg::ALU_SLTI:  result = {{(`XLEN-1){1'b0}}, $signed(rs1_data) < $signed(ctrl.imm)};
            isa_pkg::ALU_SLTIU: result = {{(`XLEN-1){1'b0}}, rs1_data < ctrl.imm};
            isa_pkg::ALU_XORI:  result = rs1_data ^ ctrl.imm;
            isa_pkg::ALU_ORI:   result = rs1_data | ctrl.imm;
            isa_pkg::ALU_ANDI:  result = rs1_data & ctrl.imm;
            isa_pkg::ALU_SLLI:  result = rs1_data << ctrl.imm[4:0];
            isa_pkg::ALU_SRLI:  result = rs1_data >> ctrl.imm[4:0];
            isa_pkg::ALU_SRAI:  result = $signed(rs1_data) >>> ctrl.imm[4:0];
            isa_pkg::ALU_JALR:  result = {rs1_imm[`XLEN-1:1], 1'b0};  // Bit 0 cleared
            isa_pkg::ALU_LUI:   result = ctrl.imm;
            isa_pkg::ALU_AUIPC, isa_pkg::ALU_JAL,
            isa_pkg::ALU_BEQ, isa_pkg::ALU_BNE, isa_pkg::ALU_BLT,
            isa_pkg::ALU_BGE, isa_pkg::ALU_BLTU, isa_pkg::ALU_BGEU: result = pc_imm;
            isa_pkg::ALU_NOP:   result = '0;
            default:            result = rs1_imm;  // ADDI, loads and stores
        endcase
    end

    always_comb begin
        case (ctrl.alu_op)
            isa_pkg::ALU_BEQ:  branch_taken = eq;
            isa_pkg::ALU_BNE:  branch_taken = !eq;
            isa_pkg::ALU_BLT:  branch_taken = lt;
            isa_pkg::ALU_BGE:  branch_taken = !lt;
            isa_pkg::ALU_BLTU: branch_taken = ltu;
            isa_pkg::ALU_BGEU: branch_taken = !ltu;
            default:           branch_taken = 1'b0;
        endcase
    end

endmodule

// File: execute/register_file.sv
`timescale 1ns/1ps
`include "rv_params.svh"

module register_file (
    input  logic                            clk,
    input  logic                            reset,
    input  logic [core_pkg::REG_IDX_W-1:0]  rs1,
    input  logic [core_pkg::REG_IDX_W-1:0]  rs2,
    output logic [`XLEN-1:0]                rs1_data,
    output logic [`XLEN-1:0]                rs2_data,
    input  core_pkg::wb_t                   wb
);

    logic [`XLEN-1:0] regs [1:`REG_COUNT-1];  // No storage for x0

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 1; i < `REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (wb.valid && (wb.rd != '0)) begin
            regs[wb.rd] <= wb.data;
        end
    end

    assign rs1_data = (rs1 == '0) ? '0 : regs[rs1];
    assign rs2_data = (rs2 == '0) ? '0 : regs[rs2];

endmodule

// File: source/memory_handler.sv
`timescale 1ns/1ps
`include "rv_params.svh"

module memory_handler (
    input  logic              clk,
    input  logic              reset,
    input  core_pkg::decode_t ctrl,
    input  core_pkg::exec_t   exec,
    input  logic [`XLEN-1:0]  pc,
    output core_pkg::wb_t     wb
);

    localparam int ADDR_W = $clog2(`DMEM_WORDS);

    logic [`XLEN-1:0]  dmem [`DMEM_WORDS];
    logic [ADDR_W-1:0] word_idx;
    logic [1:0]        byte_off;
    logic [3:0]        byte_en;
    logic [`XLEN-1:0]  wdata;     // Store data replicated across lanes
    logic [`XLEN-1:0]  rdata;
    logic [`XLEN-1:0]  lane;      // Addressed byte moved down to bit 0
    logic [`XLEN-1:0]  load_data;

    assign word_idx = exec.alu_result[ADDR_W+1:2];
    assign byte_off = exec.alu_result[1:0];

    always_comb begin
        case (ctrl.alu_op)
            isa_pkg::ALU_SB: begin
                byte_en = 4'b0001 << byte_off;
                wdata   = {4{exec.store_data[7:0]}};
            end
            isa_pkg::ALU_SH: begin
                byte_en = 4'b0011 << byte_off;
                wdata   = {2{exec.store_data[15:0]}};
            end
            default: begin
                byte_en = 4'b1111;
                wdata   = exec.store_data;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (!reset && ctrl.mem_write) begin
            for (int i = 0; i < 4; i++) begin
                if (byte_en[i]) dmem[word_idx][8*i +: 8] <= wdata[8*i +: 8];
            end
        end
    end

    assign rdata = ctrl.mem_read ? dmem[word_idx] : '0;
    assign lane  = rdata >> {byte_off, 3'b000};

    always_comb begin
        case (ctrl.alu_op)
            isa_pkg::ALU_LB:  load_data = {{24{lane[7]}}, lane[7:0]};
            isa_pkg::ALU_LH:  load_data = {{16{lane[15]}}, lane[15:0]};
            isa_pkg::ALU_LBU: load_data = {24'b0, lane[7:0]};
            isa_pkg::ALU_LHU: load_data = {16'b0, lane[15:0]};
            default:          load_data = rdata;  // LW
        endcase
    end

    always_comb begin
        wb.valid = ctrl.reg_write && (ctrl.rd != '0) && !reset;
        wb.rd    = ctrl.rd;
        case (ctrl.wb_sel)
            isa_pkg::WB_MEM:  wb.data = load_data;
            isa_pkg::WB_LINK: wb.data = pc + `XLEN'd4;
            isa_pkg::WB_ALU:  wb.data = exec.alu_result;
            default:          wb.data = '0;
        endcase
    end

endmodule

// File: source/core_top.sv
`timescale 1ns/1ps
`include "rv_params.svh"

module core_top (
    input  logic              clk,
    input  logic              reset,
    output logic [`XLEN-1:0]  instr_addr,
    input  logic [`XLEN-1:0]  instruction,
    output core_pkg::wb_t     wb
);

    logic [`XLEN-1:0]  pc;
    logic [`XLEN-1:0]  rs1_data;
    logic [`XLEN-1:0]  rs2_data;
    core_pkg::decode_t ctrl;
    core_pkg::exec_t   exec;

    assign instr_addr      = pc;
    assign exec.store_data = rs2_data;

    fetch_unit fetch_i (
        .clk   (clk),
        .reset (reset),
        .jump  (ctrl.jump),
        .exec  (exec),
        .pc    (pc)
    );

    control_unit decode_i (
        .instruction (instruction),
        .ctrl        (ctrl)
    );

    register_file regs_i (
        .clk      (clk),
        .reset    (reset),
        .rs1      (ctrl.rs1_en ? ctrl.rs1 : '0),  // Unused fields read x0
        .rs2      (ctrl.rs2_en ? ctrl.rs2 : '0),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data),
        .wb       (wb)
    );

    alu alu_i (
        .ctrl         (ctrl),
        .rs1_data     (rs1_data),
        .rs2_data     (rs2_data),
        .pc           (pc),
        .result       (exec.alu_result),
        .branch_taken (exec.branch_taken)
    );

    memory_handler mem_i (
        .clk   (clk),
        .reset (reset),
        .ctrl  (ctrl),
        .exec  (exec),
        .pc    (pc),
        .wb    (wb)
    );

endmodule

// File: verification/core_tb.sv
`timescale 1ns/1ps
`include "rv_params.svh"

module core_tb;

    typedef struct {
        logic [31:0] instr;
        logic        valid;
        logic [4:0]  rd;
        logic [31:0] data;
        logic [31:0] next_pc;  // Expected path after this entry
    } entry_t;

    localparam logic [31:0] nop_instr = 32'h0000_0013;  // addi x0, x0, 0

    logic             clk = 1'b0;
    logic             reset;
    logic [`XLEN-1:0] instr_addr;
    logic [`XLEN-1:0] instruction;
    core_pkg::wb_t    wb;

    entry_t      prog [$];
    logic [31:0] xreg [32];                   // Architectural register model
    logic [7:0]  mem_model [logic [31:0]];    // Byte-lane data memory model
    logic [31:0] lfsr_state = 32'h9951_d1ff;
    logic        prog_ready = 1'b0;

    core_top dut_i (
        .clk         (clk),
        .reset       (reset),
        .instr_addr  (instr_addr),
        .instruction (instruction),
        .wb          (wb)
    );

    always #2 clk = ~clk;

    // Instruction memory indexed by the fetch word address
    always @(posedge clk) begin
        #1;
        instruction = fetch_word(instr_addr);
    end

    function automatic logic [31:0] fetch_word(input logic [31:0] addr);
        int idx;
        idx = int'(addr >> 2);
        if (idx < prog.size()) return prog[idx].instr;
        return nop_instr;  // Outside the program
    endfunction

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ({1'b0, s[31:1]} ^ 32'hD000_0001) : {1'b0, s[31:1]};
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            r = {r[30:0], lfsr_state[0]};  // One step per bit
            lfsr_state = lfsr_next(lfsr_state);
        end
        return r;
    endfunction

    function automatic logic [31:0] sext12(input int v);
        return {{20{v[11]}}, v[11:0]};
    endfunction

    function automatic int size_bytes(input int f3);
        return (f3[1:0] == 2'd0) ? 1 : (f3[1:0] == 2'd1) ? 2 : 4;
    endfunction

    function automatic logic [31:0] enc_r(input int f7, input int rs2, input int rs1,
                                          input int f3, input int rd);
        return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], isa_pkg::OPC_OP};
    endfunction

    function automatic logic [31:0] enc_i(input int imm, input int rs1, input int f3,
                                          input int rd, input isa_pkg::opcode_e op);
        return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], op};
    endfunction

    function automatic logic [31:0] enc_s(input int imm, input int rs2, input int rs1,
                                          input int f3);
        return {imm[11:5], rs2[4:0], rs1[4:0], f3[2:0], imm[4:0], isa_pkg::OPC_STORE};
    endfunction

    function automatic logic [31:0] enc_b(input int imm, input int rs2, input int rs1,
                                          input int f3);
        return {imm[12], imm[10:5], rs2[4:0], rs1[4:0], f3[2:0], imm[4:1], imm[11],
                isa_pkg::OPC_BRANCH};
    endfunction

    function automatic logic [31:0] enc_u(input logic [19:0] imm, input int rd,
                                          input isa_pkg::opcode_e op);
        return {imm, rd[4:0], op};
    endfunction

    function automatic logic [31:0] enc_j(input int imm, input int rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd[4:0], isa_pkg::OPC_JAL};
    endfunction

    function automatic logic [31:0] cur_pc();
        return 32'(prog.size() * 4);
    endfunction

    task automatic add_entry(input logic [31:0] instr, input int rd, input logic wr,
                             input logic [31:0] data, input logic [31:0] next_pc);
        entry_t e;
        e.instr   = instr;
        e.valid   = wr && (rd != 0);  // x0 writes never show on the port
        e.rd      = rd[4:0];
        e.data    = data;
        e.next_pc = next_pc;
        prog.push_back(e);
        if (e.valid) xreg[rd] = data;
    endtask

    task automatic seq(input logic [31:0] instr, input int rd, input logic wr,
                       input logic [31:0] data);
        add_entry(instr, rd, wr, data, cur_pc() + 32'd4);
    endtask

    task automatic load_const(input int rd, input logic [31:0] v);
        logic [19:0] hi;
        hi = v[31:12] + 20'(v[11]);  // Compensates the sign of the low part
        seq(enc_u(hi, rd, isa_pkg::OPC_LUI), rd, 1'b1, {hi, 12'b0});
        seq(enc_i(int'(v[11:0]), rd, 0, rd, isa_pkg::OPC_OP_IMM), rd, 1'b1,
            xreg[rd] + sext12(int'(v[11:0])));
    endtask

    task automatic store(input int f3, input int rs2, input int rs1, input int off);
        logic [31:0] addr;
        addr = xreg[rs1] + sext12(off);
        for (int i = 0; i < size_bytes(f3); i++) begin
            mem_model[addr + 32'(i)] = xreg[rs2][8*i +: 8];
        end
        seq(enc_s(off, rs2, rs1, f3), 0, 1'b0, '0);
    endtask

    task automatic load(input int f3, input int rd, input int rs1, input int off);
        logic [31:0] addr;
        logic [31:0] word;
        logic [31:0] data;
        addr = xreg[rs1] + sext12(off);
        word = '0;
        for (int i = 0; i < size_bytes(f3); i++) begin
            word[8*i +: 8] = mem_model[addr + 32'(i)];
        end
        case (f3)
            0:       data = {{24{word[7]}}, word[7:0]};
            1:       data = {{16{word[15]}}, word[15:0]};
            4:       data = {24'b0, word[7:0]};
            5:       data = {16'b0, word[15:0]};
            default: data = word;
        endcase
        seq(enc_i(off, rs1, f3, rd, isa_pkg::OPC_LOAD), rd, 1'b1, data);
    endtask

    task automatic branch(input int f3, input int rs1, input int rs2);
        logic [31:0] a;
        logic [31:0] b;
        logic        taken;
        a = xreg[rs1];
        b = xreg[rs2];
        case (f3)
            0:       taken = a == b;
            1:       taken = a != b;
            4:       taken = $signed(a) < $signed(b);
            5:       taken = $signed(a) >= $signed(b);
            6:       taken = a < b;
            default: taken = a >= b;
        endcase
        add_entry(enc_b(8, rs2, rs1, f3), 0, 1'b0, '0,
                  taken ? cur_pc() + 32'd8 : cur_pc() + 32'd4);
        seq(nop_instr, 0, 1'b0, '0);  // Skipped when taken
    endtask

    task automatic build_program();
        logic [31:0] a;
        logic [31:0] b;
        logic [19:0] u;
        int          imm;
        int          sh;
        int          base;
        int          v;
        int          br_f3 [6] = '{0, 1, 4, 5, 6, 7};
        for (int i = 0; i < 32; i++) xreg[i] = '0;
        load_const(1, rand_bits(32));
        load_const(2, rand_bits(32));
        a = xreg[1];
        b = xreg[2];
        seq(enc_r(0, 2, 1, 0, 3), 3, 1'b1, a + b);
        seq(enc_r('h20, 2, 1, 0, 4), 4, 1'b1, a - b);
        seq(enc_r(0, 2, 1, 1, 5), 5, 1'b1, a << b[4:0]);
        seq(enc_r(0, 2, 1, 2, 6), 6, 1'b1, {31'b0, $signed(a) < $signed(b)});
        seq(enc_r(0, 2, 1, 3, 7), 7, 1'b1, {31'b0, a < b});
        seq(enc_r(0, 2, 1, 4, 8), 8, 1'b1, a ^ b);
        seq(enc_r(0, 2, 1, 5, 9), 9, 1'b1, a >> b[4:0]);
        seq(enc_r('h20, 2, 1, 5, 10), 10, 1'b1, 32'($signed(a) >>> b[4:0]));
        seq(enc_r(0, 2, 1, 6, 11), 11, 1'b1, a | b);
        seq(enc_r(0, 2, 1, 7, 12), 12, 1'b1, a & b);
        imm = int'(rand_bits(12));
        seq(enc_i(imm, 1, 0, 13, isa_pkg::OPC_OP_IMM), 13, 1'b1, a + sext12(imm));
        imm = int'(rand_bits(12));
        seq(enc_i(imm, 1, 2, 14, isa_pkg::OPC_OP_IMM), 14, 1'b1,
            {31'b0, $signed(a) < $signed(sext12(imm))});
        imm = int'(rand_bits(12));
        seq(enc_i(imm, 1, 3, 15, isa_pkg::OPC_OP_IMM), 15, 1'b1, {31'b0, a < sext12(imm)});
        imm = int'(rand_bits(12));
        seq(enc_i(imm, 1, 4, 16, isa_pkg::OPC_OP_IMM), 16, 1'b1, a ^ sext12(imm));
        imm = int'(rand_bits(12));
        seq(enc_i(imm, 1, 6, 17, isa_pkg::OPC_OP_IMM), 17, 1'b1, a | sext12(imm));
        imm = int'(rand_bits(12));
        seq(enc_i(imm, 1, 7, 18, isa_pkg::OPC_OP_IMM), 18, 1'b1, a & sext12(imm));
        sh = int'(rand_bits(5));
        seq(enc_i(sh, 1, 1, 19, isa_pkg::OPC_OP_IMM), 19, 1'b1, a << sh);
        seq(enc_i(sh, 1, 5, 20, isa_pkg::OPC_OP_IMM), 20, 1'b1, a >> sh);
        seq(enc_i('h400 | sh, 1, 5, 21, isa_pkg::OPC_OP_IMM), 21, 1'b1,
            32'($signed(a) >>> sh));
        seq(enc_r(0, 2, 1, 0, 0), 0, 1'b1, a + b);   // Write to x0 is dropped
        seq(enc_r(0, 1, 0, 0, 22), 22, 1'b1, a);     // x0 reads as zero
        u = 20'(rand_bits(20));
        seq(enc_u(u, 23, isa_pkg::OPC_LUI), 23, 1'b1, {u, 12'b0});
        u = 20'(rand_bits(20));
        seq(enc_u(u, 24, isa_pkg::OPC_AUIPC), 24, 1'b1, cur_pc() + {u, 12'b0});
        base = `DMEM_WORDS * 2 + 4;                  // Middle of the data RAM
        seq(enc_i(base, 0, 0, 25, isa_pkg::OPC_OP_IMM), 25, 1'b1, sext12(base));
        store(2, 1, 25, -4);
        store(1, 2, 25, -2);
        store(0, 3, 25, -3);
        load(2, 26, 25, -4);
        load(1, 27, 25, -2);
        load(5, 28, 25, -2);
        load(0, 29, 25, -3);
        load(4, 30, 25, -3);
        load(0, 31, 25, -1);
        foreach (br_f3[i]) begin
            branch(br_f3[i], 1, 2);
            if (br_f3[i] < 2) branch(br_f3[i], 1, 1);
            else branch(br_f3[i], 2, 1);
        end
        add_entry(enc_j(8, 5), 5, 1'b1, cur_pc() + 32'd4, cur_pc() + 32'd8);
        seq(nop_instr, 0, 1'b0, '0);
        v = prog.size() * 4 + 9;                      // Odd target base for JALR
        seq(enc_i(v, 0, 0, 6, isa_pkg::OPC_OP_IMM), 6, 1'b1, sext12(v));
        add_entry(enc_i(4, 6, 0, 7, isa_pkg::OPC_JALR), 7, 1'b1, cur_pc() + 32'd4,
                  (xreg[6] + sext12(4)) & ~32'd1);
        seq(nop_instr, 0, 1'b0, '0);
        seq(enc_r(0, 7, 5, 0, 8), 8, 1'b1, xreg[5] + xreg[7]);  // Both link values
    endtask

    task automatic report_error(input string msg);
        $display("ERROR at %0d ns: %s", $time, msg);
        $display("Test FAILED");
        $fatal(1, "Check failed");
    endtask

    task automatic check_wb(input core_pkg::wb_t got, input core_pkg::wb_t exp);
        if (got.valid !== exp.valid) begin
            report_error($sformatf("wb.valid %b, expected %b", got.valid, exp.valid));
        end else if (exp.valid && (got.rd !== exp.rd || got.data !== exp.data)) begin
            report_error($sformatf("wb x%0d = 0x%08h, expected x%0d = 0x%08h",
                                   got.rd, got.data, exp.rd, exp.data));
        end
    endtask

    task automatic check_pc(input logic [`XLEN-1:0] got, input logic [`XLEN-1:0] exp);
        if (got !== exp) begin
            report_error($sformatf("instr_addr 0x%08h, expected 0x%08h", got, exp));
        end
    endtask

    initial begin
        core_pkg::wb_t exp_wb;
        logic [31:0]   exp_pc;
        int            idx;
        reset       = 1'b1;
        instruction = nop_instr;
        build_program();
        prog_ready = 1'b1;
        @(posedge clk);
        #2;
        check_pc(instr_addr, '0);
        check_wb(wb, '0);  // First instruction is held off by reset
        @(posedge clk);
        @(posedge clk);
        #1;
        reset  = 1'b0;
        exp_pc = '0;
        #1;
        while (exp_pc != cur_pc()) begin
            idx = int'(exp_pc >> 2);
            check_pc(instr_addr, exp_pc);
            exp_wb.valid = prog[idx].valid;
            exp_wb.rd    = prog[idx].rd;
            exp_wb.data  = prog[idx].data;
            check_wb(wb, exp_wb);
            exp_pc = prog[idx].next_pc;
            @(posedge clk);
            #2;
        end
        $display("Test OK");
        $finish;
    end

    // Every entry runs at most once, plus reset and margin
    initial begin
        wait (prog_ready);
        #((prog.size() + 10) * 4);
        $display("Timeout: the program did not reach its end in time");
        $display("Test FAILED");
        $fatal(1, "Watchdog expired");
    end

endmodule

// File: sim.f
+incdir+common
common/isa_pkg.sv
common/core_pkg.sv
fetch/fetch_unit.sv
decode/control_unit.sv
execute/alu.sv
execute/register_file.sv
source/memory_handler.sv
source/core_top.sv
verification/core_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= core_tb
FILELIST  ?= sim.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?=

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) --binary --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR) $(VFLAGS)

run: build
	./$(OBJ_DIR)/V$(TOP)

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST) $(VFLAGS)

clean:
	rm -rf $(OBJ_DIR)
